/* flist.f */
verilog/apb_periph_pkg.sv
verilog/apb_decoder.sv
verilog/gpio_port.sv
verilog/riscv_timer.sv
verilog/apb_response_mux.sv
verilog/apb_periph_top.sv
bench/apb_periph_assert.sv
bench/apb_periph_tb.sv

/* Bender.yml */
package:
  name: apb_periph

sources:
  - verilog/apb_periph_pkg.sv
  - verilog/apb_decoder.sv
  - verilog/gpio_port.sv
  - verilog/riscv_timer.sv
  - verilog/apb_response_mux.sv
  - verilog/apb_periph_top.sv
  - target: test
    files:
      - bench/apb_periph_assert.sv
      - bench/apb_periph_tb.sv

/* bench/apb_periph_tb.sv */
// APB peripheral subsystem testbench
`timescale 1ns/1ps

module apb_periph_tb;

	import apb_periph_pkg::*;

	localparam int N_GPIO  = 2;
	localparam int CLK_MHZ = 12;
	localparam int TIMEOUT = 32;

	logic                    clk;
	logic                    rst_n;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	logic                    hart_halted;
	apb_addr_t               paddr;
	apb_data_t               pwdata;
	gpio_word_t [N_GPIO-1:0] gpio_in;
	logic                    pready;
	logic                    pslverr;
	logic                    timer_irq;
	apb_data_t               prdata;
	gpio_word_t [N_GPIO-1:0] gpio_out;
	gpio_word_t [N_GPIO-1:0] gpio_oe;
	logic [N_GPIO-1:0]       gpio_irq;

	logic [31:0] lfsr = 32'hc4b44964;
	int          value_errors;
	int          protocol_errors;
	int          timeout_errors;
	// register model
	gpio_word_t  exp_dout [N_GPIO];
	gpio_word_t  exp_oe [N_GPIO];
	gpio_word_t  exp_ien [N_GPIO];
	gpio_word_t  exp_istat [N_GPIO];
	gpio_word_t  last_in [N_GPIO];

	apb_periph_top #(
		.N_GPIO  (N_GPIO),
		.CLK_MHZ (CLK_MHZ)
	) i_apb_periph_top (.*);

	initial begin
		clk = 1'b1;
		forever #2 clk = ~clk;
	end

	// protocol monitor next to the bound assertions
	always @(posedge clk) begin
		if (rst_n && ((penable && !pready) || (pslverr && !(psel && penable))
				|| $countones(i_apb_periph_top.slot_sel) > 1)) begin
			protocol_errors++;
			$display("APB protocol rule broken at time %0t", $time);
		end
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic apb_addr_t slot_addr(input int k, input logic [15:0] off);
		return SLOT_BASE + SLOT_STRIDE * apb_addr_t'(k) + apb_addr_t'(off);
	endfunction

	task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_pins(input string name, input gpio_word_t exp, input gpio_word_t act);
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("ERROR %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic report_counts();
		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errors, protocol_errors, timeout_errors);
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
		end
	endtask

	// setup then access, entered and left on a falling edge
	task automatic bus_access(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		int waited;
		waited = 0;
		psel = 1'b1;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		while (!pready && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (!pready) begin
			timeout_errors++;
			$display("pready never rose within %0d cycles at address %h", TIMEOUT, addr);
			report_counts();
			$display("*** FAILED ***");
			$finish;
		end else begin
			rdata = prdata;
			err = pslverr;
			@(negedge clk);
			psel = 1'b0;
			penable = 1'b0;
			pwrite = 1'b0;
		end
	endtask

	task automatic bus_write(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rdata;
		logic      err;
		bus_access(addr, 1'b1, data, rdata, err);
		check_bit("pslverr", 1'b0, err);
	endtask

	task automatic bus_read(input apb_addr_t addr, output apb_data_t rdata);
		logic err;
		bus_access(addr, 1'b0, '0, rdata, err);
		check_bit("pslverr", 1'b0, err);
	endtask

	task automatic readback_regs();
		int          p;
		logic [15:0] off;
		apb_data_t   wdata;
		apb_data_t   rdata;
		for (int i = 0; i < 24; i++) begin
			p = int'(rand_bits(1)) % N_GPIO;
			wdata = rand_bits(32);
			case (rand_bits(2) % 3)
				0: begin
					off = GPIO_DOUT;
					exp_dout[p] = wdata[7:0];
				end
				1: begin
					off = GPIO_OE;
					exp_oe[p] = wdata[7:0];
				end
				default: begin
					off = GPIO_IEN;
					exp_ien[p] = wdata[7:0];
				end
			endcase
			bus_write(slot_addr(p, off), wdata);
			bus_read(slot_addr(p, off), rdata);
			check_data("prdata", {24'h0, wdata[7:0]}, rdata);
			for (int q = 0; q < N_GPIO; q++) begin
				check_pins("gpio_out", exp_dout[q], gpio_out[q]);
				check_pins("gpio_oe", exp_oe[q], gpio_oe[q]);
			end
		end
	endtask

	task automatic edge_interrupts();
		gpio_word_t clr;
		apb_data_t  rdata;
		for (int i = 0; i < 16; i++) begin
			for (int p = 0; p < N_GPIO; p++) begin
				exp_ien[p] = gpio_word_t'(rand_bits(8));
				bus_write(slot_addr(p, GPIO_IEN), {24'h0, exp_ien[p]});
				gpio_in[p] = gpio_word_t'(rand_bits(8));
				// rising edges stay sticky until cleared
				exp_istat[p] |= gpio_in[p] & ~last_in[p];
				last_in[p] = gpio_in[p];
			end
			wait_cycles(4);
			for (int p = 0; p < N_GPIO; p++) begin
				bus_read(slot_addr(p, GPIO_DIN), rdata);
				check_data("gpio din", {24'h0, last_in[p]}, rdata);
				bus_read(slot_addr(p, GPIO_ISTAT), rdata);
				check_data("gpio istat", {24'h0, exp_istat[p]}, rdata);
				check_bit("gpio_irq", |(exp_istat[p] & exp_ien[p]), gpio_irq[p]);
				clr = gpio_word_t'(rand_bits(8));
				bus_write(slot_addr(p, GPIO_ISTAT), {24'h0, clr});
				exp_istat[p] &= ~clr;
				check_bit("gpio_irq", |(exp_istat[p] & exp_ien[p]), gpio_irq[p]);
			end
		end
	endtask

	task automatic decode_errors();
		apb_addr_t addr;
		apb_data_t rdata;
		logic      err;
		for (int i = 0; i < 20; i++) begin
			addr = rand_bits(32);
			// miss by the top nibble or by a slot index past the timer
			if (rand_bits(1)) begin
				addr[31:28] = (addr[31:28] == SLOT_BASE[31:28]) ? 4'h5 : addr[31:28];
			end else begin
				addr[31:28] = SLOT_BASE[31:28];
				addr[23:16] = 8'(N_GPIO + 1) + 8'(rand_bits(7));
			end
			bus_access(addr, 1'(rand_bits(1)), rand_bits(32), rdata, err);
			check_bit("pslverr", 1'b1, err);
			check_data("prdata", '0, rdata);
			// mapped slot, unknown offset, bits 27:24 are don't care
			addr = slot_addr(int'(rand_bits(2)) % (N_GPIO + 1), 16'h0100 + 16'(rand_bits(8)));
			addr[27:24] = 4'(rand_bits(4));
			bus_access(addr, 1'b0, '0, rdata, err);
			check_bit("pslverr", 1'b0, err);
			check_data("prdata", '0, rdata);
		end
	endtask

	task automatic timer_compare();
		logic [63:0] mt;
		logic [63:0] cmp;
		apb_data_t   rdata;
		// large enough that the compare offsets never wrap
		mt = {2'b01, 30'(rand_bits(30)), rand_bits(32)};
		bus_write(slot_addr(N_GPIO, TMR_MTIME_LO), mt[31:0]);
		bus_write(slot_addr(N_GPIO, TMR_MTIME_HI), mt[63:32]);
		bus_read(slot_addr(N_GPIO, TMR_MTIME_LO), rdata);
		check_data("mtime_lo", mt[31:0], rdata);
		bus_read(slot_addr(N_GPIO, TMR_MTIME_HI), rdata);
		check_data("mtime_hi", mt[63:32], rdata);
		for (int i = 0; i < 8; i++) begin
			if (rand_bits(1)) begin
				cmp = mt - 64'(rand_bits(4));
			end else begin
				cmp = mt + 64'(rand_bits(4)) + 64'd1;
			end
			bus_write(slot_addr(N_GPIO, TMR_CMP_LO), cmp[31:0]);
			bus_write(slot_addr(N_GPIO, TMR_CMP_HI), cmp[63:32]);
			check_bit("timer_irq", cmp <= mt, timer_irq);
		end
	endtask

	task automatic timer_count();
		apb_data_t t0;
		apb_data_t t1;
		apb_data_t v;
		int        n;
		bus_write(slot_addr(N_GPIO, TMR_MTIME_HI), '0);
		bus_write(slot_addr(N_GPIO, TMR_MTIME_LO), '0);
		bus_write(slot_addr(N_GPIO, TMR_CTRL), 32'h1);
		for (int i = 0; i < 4; i++) begin
			n = 4 + int'(rand_bits(3));
			bus_read(slot_addr(N_GPIO, TMR_MTIME_LO), t0);
			wait_cycles(n * CLK_MHZ);
			bus_read(slot_addr(N_GPIO, TMR_MTIME_LO), t1);
			if (t1 - t0 < n - 1 || t1 - t0 > n + 1) begin
				value_errors++;
				$display("ERROR mtime advance: expected %h to %h, got %h", n - 1, n + 1, t1 - t0);
			end
		end
		// halted hart freezes the count
		hart_halted = 1'b1;
		v = rand_bits(32);
		bus_write(slot_addr(N_GPIO, TMR_MTIME_LO), v);
		bus_read(slot_addr(N_GPIO, TMR_MTIME_LO), t0);
		check_data("mtime_lo", v, t0);
		wait_cycles(3 * CLK_MHZ);
		bus_read(slot_addr(N_GPIO, TMR_MTIME_LO), t1);
		check_data("mtime_lo", v, t1);
		hart_halted = 1'b0;
	endtask

	initial begin
		value_errors = 0;
		protocol_errors = 0;
		timeout_errors = 0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		hart_halted = 1'b0;
		paddr = '0;
		pwdata = '0;
		gpio_in = '0;
		for (int p = 0; p < N_GPIO; p++) begin
			exp_dout[p] = '0;
			exp_oe[p] = '0;
			exp_ien[p] = '0;
			exp_istat[p] = '0;
			last_in[p] = '0;
		end
		wait_cycles(16);
		rst_n = 1'b1;
		wait_cycles(1);
		check_bit("timer_irq", 1'b0, timer_irq);
		check_bit("gpio_irq", 1'b0, |gpio_irq);
		readback_regs();
		edge_interrupts();
		decode_errors();
		timer_compare();
		timer_count();
		report_counts();
		if (value_errors == 0 && protocol_errors == 0 && timeout_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* bench/apb_periph_assert.sv */
// APB protocol assertions
`timescale 1ns/1ps

module apb_periph_assert #(
	parameter int N_GPIO = 2
) (
	input logic            clk,
	input logic            rst_n,
	input logic            psel,
	input logic            penable,
	input logic            pready,
	input logic            pslverr,
	input logic [N_GPIO:0] slot_sel
);

	// no wait states in any access
	a_ready: assert property (@(posedge clk) disable iff (!rst_n)
		psel && penable |-> pready)
		else $error("pready low in an access cycle");

	a_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(slot_sel))
		else $error("several slots selected at once");

	// error response only in the access phase
	a_err: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(pslverr) |-> psel && penable)
		else $error("pslverr rose outside an access cycle");

endmodule

bind apb_periph_top apb_periph_assert #(
	.N_GPIO (N_GPIO)
) i_apb_periph_assert (
	.clk      (clk),
	.rst_n    (rst_n),
	.psel     (psel),
	.penable  (penable),
	.pready   (pready),
	.pslverr  (pslverr),
	.slot_sel (slot_sel)
);

/* verilog/apb_periph_top.sv */
// APB peripheral subsystem
`timescale 1ns/1ps

module apb_periph_top #(
	parameter int N_GPIO  = 2,
	parameter int CLK_MHZ = 12
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    psel,
	input  logic                                    penable,
	input  logic                                    pwrite,
	input  logic                                    hart_halted,
	input  apb_periph_pkg::apb_addr_t               paddr,
	input  apb_periph_pkg::apb_data_t               pwdata,
	input  apb_periph_pkg::gpio_word_t [N_GPIO-1:0] gpio_in,
	output logic                                    pready,
	output logic                                    pslverr,
	output logic                                    timer_irq,
	output apb_periph_pkg::apb_data_t               prdata,
	output apb_periph_pkg::gpio_word_t [N_GPIO-1:0] gpio_out,
	output apb_periph_pkg::gpio_word_t [N_GPIO-1:0] gpio_oe,
	output logic [N_GPIO-1:0]                       gpio_irq
);

	import apb_periph_pkg::*;

	logic [N_GPIO:0] slot_sel;
	logic            miss;
	apb_data_t       slot_rdata [N_GPIO+1];

	apb_decoder #(
		.N_GPIO (N_GPIO)
	) i_apb_decoder (
		.psel     (psel),
		.paddr    (paddr),
		.slot_sel (slot_sel),
		.miss     (miss)
	);

	// gpio ports take slots 0 to N_GPIO-1
	for (genvar g = 0; g < N_GPIO; g++) begin : g_gpio
		gpio_port i_gpio_port (
			.clk      (clk),
			.rst_n    (rst_n),
			.sel      (slot_sel[g]),
			.penable  (penable),
			.pwrite   (pwrite),
			.offset   (paddr[15:0]),
			.pwdata   (pwdata),
			.gpio_in  (gpio_in[g]),
			.prdata   (slot_rdata[g]),
			.gpio_out (gpio_out[g]),
			.gpio_oe  (gpio_oe[g]),
			.gpio_irq (gpio_irq[g])
		);
	end

	// timer in the slot after the last port
	riscv_timer #(
		.CLK_MHZ (CLK_MHZ)
	) i_riscv_timer (
		.clk         (clk),
		.rst_n       (rst_n),
		.sel         (slot_sel[N_GPIO]),
		.penable     (penable),
		.pwrite      (pwrite),
		.hart_halted (hart_halted),
		.offset      (paddr[15:0]),
		.pwdata      (pwdata),
		.prdata      (slot_rdata[N_GPIO]),
		.timer_irq   (timer_irq)
	);

	apb_response_mux #(
		.N_GPIO (N_GPIO)
	) i_apb_response_mux (
		.penable    (penable),
		.miss       (miss),
		.slot_sel   (slot_sel),
		.slot_rdata (slot_rdata),
		.pready     (pready),
		.prdata     (prdata),
		.pslverr    (pslverr)
	);

endmodule

/* verilog/apb_response_mux.sv */
// APB completer response mux
`timescale 1ns/1ps

module apb_response_mux #(
	parameter int N_GPIO = 2
) (
	input  logic                      penable,
	input  logic                      miss,
	input  logic [N_GPIO:0]           slot_sel,
	input  apb_periph_pkg::apb_data_t slot_rdata [N_GPIO+1],
	output logic                      pready,
	output apb_periph_pkg::apb_data_t prdata,
	output logic                      pslverr
);

	import apb_periph_pkg::*;

	apb_data_t rdata_or;

	// select is one-hot, so an OR reduction picks the slot
	always_comb begin
		rdata_or = '0;
		for (int k = 0; k <= N_GPIO; k++) begin
			if (slot_sel[k]) begin
				rdata_or = rdata_or | slot_rdata[k];
			end
		end
	end

	assign prdata = rdata_or;

	// zero wait states everywhere
	assign pready  = penable;
	assign pslverr = penable && miss;

endmodule

/* verilog/riscv_timer.sv */
// RISC-V machine timer
`timescale 1ns/1ps

module riscv_timer #(
	parameter int CLK_MHZ = 12
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      sel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic                      hart_halted,
	input  logic [15:0]               offset,
	input  apb_periph_pkg::apb_data_t pwdata,
	output apb_periph_pkg::apb_data_t prdata,
	output logic                      timer_irq
);

	import apb_periph_pkg::*;

	// keep at least one bit when CLK_MHZ is 1
	localparam int TW = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;

	logic [TW-1:0] tick_ctr;
	logic          tick;
	logic          ctrl_en;
	logic [63:0]   mtime;
	logic [63:0]   mtimecmp;
	logic          wr_en;
	logic          count_en;

	assign wr_en    = sel && penable && pwrite;
	assign tick     = ~|tick_ctr;
	assign count_en = ctrl_en && tick && !hart_halted;

	// microsecond timebase, reloads at zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= '0;
		end else if (tick) begin
			tick_ctr <= TW'(CLK_MHZ - 1);
		end else begin
			tick_ctr <= tick_ctr - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en  <= 1'b0;
			mtime    <= '0;
			mtimecmp <= '1;
		end else begin
			if (wr_en && offset == TMR_CTRL) begin
				ctrl_en <= pwdata[0];
			end
			if (wr_en && offset == TMR_CMP_LO) begin
				mtimecmp[31:0] <= pwdata;
			end
			if (wr_en && offset == TMR_CMP_HI) begin
				mtimecmp[63:32] <= pwdata;
			end
			// bus write to either half takes priority over the count
			if (wr_en && offset == TMR_MTIME_LO) begin
				mtime[31:0] <= pwdata;
			end else if (wr_en && offset == TMR_MTIME_HI) begin
				mtime[63:32] <= pwdata;
			end else if (count_en) begin
				mtime <= mtime + 64'd1;
			end
		end
	end

	always_comb begin
		case (offset)
			TMR_CTRL:     prdata = {31'h0, ctrl_en};
			TMR_MTIME_LO: prdata = mtime[31:0];
			TMR_MTIME_HI: prdata = mtime[63:32];
			TMR_CMP_LO:   prdata = mtimecmp[31:0];
			TMR_CMP_HI:   prdata = mtimecmp[63:32];
			default:      prdata = '0;
		endcase
	end

	assign timer_irq = (mtime >= mtimecmp);

endmodule

/* verilog/gpio_port.sv */
// 8-bit GPIO port
`timescale 1ns/1ps

module gpio_port (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       sel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [15:0]                offset,
	input  apb_periph_pkg::apb_data_t  pwdata,
	input  apb_periph_pkg::gpio_word_t gpio_in,
	output apb_periph_pkg::apb_data_t  prdata,
	output apb_periph_pkg::gpio_word_t gpio_out,
	output apb_periph_pkg::gpio_word_t gpio_oe,
	output logic                       gpio_irq
);

	import apb_periph_pkg::*;

	gpio_word_t dout_q;
	gpio_word_t oe_q;
	gpio_word_t ien_q;
	gpio_word_t istat_q;
	gpio_word_t sync1_q;
	gpio_word_t sync2_q;
	gpio_word_t prev_q;
	gpio_word_t rise;
	gpio_word_t clr_mask;
	logic       wr_en;

	assign wr_en = sel && penable && pwrite;

	// edge seen one cycle after the pin shows up in DIN
	assign rise     = sync2_q & ~prev_q;
	assign clr_mask = (wr_en && offset == GPIO_ISTAT) ? pwdata[7:0] : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dout_q  <= '0;
			oe_q    <= '0;
			ien_q   <= '0;
			istat_q <= '0;
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
		end else begin
			sync1_q <= gpio_in;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
			// a fresh edge beats a clear in the same cycle
			istat_q <= (istat_q & ~clr_mask) | rise;
			if (wr_en) begin
				case (offset)
					GPIO_DOUT: dout_q <= pwdata[7:0];
					GPIO_OE:   oe_q   <= pwdata[7:0];
					GPIO_IEN:  ien_q  <= pwdata[7:0];
					default:   ;
				endcase
			end
		end
	end

	always_comb begin
		case (offset)
			GPIO_DIN:   prdata = {24'h0, sync2_q};
			GPIO_DOUT:  prdata = {24'h0, dout_q};
			GPIO_OE:    prdata = {24'h0, oe_q};
			GPIO_IEN:   prdata = {24'h0, ien_q};
			GPIO_ISTAT: prdata = {24'h0, istat_q};
			default:    prdata = '0;
		endcase
	end

	assign gpio_out = dout_q;
	assign gpio_oe  = oe_q;
	assign gpio_irq = |(istat_q & ien_q);

endmodule

/* verilog/apb_decoder.sv */
// APB slot address decoder
`timescale 1ns/1ps

module apb_decoder #(
	parameter int N_GPIO = 2
) (
	input  logic                      psel,
	input  apb_periph_pkg::apb_addr_t paddr,
	output logic [N_GPIO:0]           slot_sel,
	output logic                      miss
);

	import apb_periph_pkg::*;

	localparam int N_SLOTS = N_GPIO + 1;

	apb_addr_t masked_addr;

	assign masked_addr = paddr & SLOT_MASK;

	// one comparator per slot, timer is the last one
	for (genvar k = 0; k < N_SLOTS; k++) begin : g_slot
		localparam apb_addr_t SLOT_ADDR =
			(SLOT_BASE + SLOT_STRIDE * apb_addr_t'(k)) & SLOT_MASK;

		assign slot_sel[k] = psel && (masked_addr == SLOT_ADDR);
	end

	// selected but nothing answers
	assign miss = psel && !(|slot_sel);

endmodule

/* verilog/apb_periph_pkg.sv */
// APB peripheral definitions
package apb_periph_pkg;

	typedef logic [31:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;
	typedef logic [7:0]  gpio_word_t;

	// slot k sits at SLOT_BASE + k * SLOT_STRIDE
	localparam apb_addr_t SLOT_BASE   = 32'h4000_0000;
	localparam apb_addr_t SLOT_STRIDE = 32'h0001_0000;
	// bits 27:24 and the low half are ignored by the match
	localparam apb_addr_t SLOT_MASK   = 32'hF0FF_0000;

	// gpio register offsets
	localparam logic [15:0] GPIO_DIN   = 16'h0000;
	localparam logic [15:0] GPIO_DOUT  = 16'h0004;
	localparam logic [15:0] GPIO_OE    = 16'h0008;
	localparam logic [15:0] GPIO_IEN   = 16'h000C;
	localparam logic [15:0] GPIO_ISTAT = 16'h0010;

	// timer register offsets
	localparam logic [15:0] TMR_CTRL     = 16'h0000;
	localparam logic [15:0] TMR_MTIME_LO = 16'h0008;
	localparam logic [15:0] TMR_MTIME_HI = 16'h000C;
	localparam logic [15:0] TMR_CMP_LO   = 16'h0010;
	localparam logic [15:0] TMR_CMP_HI   = 16'h0014;

endpackage
